// ==== hdl/acq_cfg_pkg.sv ====
package acq_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // fill configuration, held stable for a whole fill
    typedef struct packed {
        logic [23:0] fill_num;         // fill counter from the trigger side
        logic [1:0]  fill_type;
        logic [22:0] num_fill_bursts;  // data records per waveform
        logic [22:0] burst_start_adr;  // in units of 8 DDR3 words
        logic [11:0] num_waveforms;
        logic [21:0] waveform_gap;     // idle cycles between waveforms
        logic [11:0] channel_tag;
    } fill_cfg_t;

    ////////////////////////////////////////////////////////////
    // one ADC sample pair, same bit order as the deserializer output
    typedef struct packed {
        logic [11:0] samp_b;  // newer sample
        logic        ovr_b;   // over-range of samp_b
        logic [11:0] samp_a;  // older sample
        logic        ovr_a;
    } adc_pair_t;

    // four pairs per word, element 0 is the oldest
    typedef adc_pair_t [3:0] adc_word_t;

endpackage

// ==== hdl/acq_rec_pkg.sv ====
package acq_rec_pkg;

    typedef enum logic [3:0] {
        REC_FILL_HDR = 4'd1,
        REC_WAVE_HDR = 4'd2,
        REC_DATA     = 4'd3,
        REC_CHECKSUM = 4'd4
    } rec_tag_e;

    ////////////////////////////////////////////////////////////
    // fill header payload, msb first
    typedef struct packed {
        logic [1:0]  marker;           // 01, never seen in sign-extended data
        logic [1:0]  unused;
        logic        self_trig;        // self-triggered format not built here
        logic        cbuf;
        logic [11:0] channel_tag;
        logic [21:0] waveform_gap;
        logic [11:0] num_waveforms;
        logic [22:0] burst_start_adr;  // ddr address bits 25:3
        logic [2:0]  adr_lsb;          // always zero
        logic [22:0] num_fill_bursts;
        logic        async_fmt;        // 0 for sync fills
        logic [1:0]  fill_type;
        logic [23:0] fill_num;
    } fill_hdr_t;

    // waveform header payload, msb first
    typedef struct packed {
        logic [1:0]  marker;
        logic [11:0] spare;
        logic [3:0]  alarms;           // xadc alarms at header time
        logic [11:0] channel_tag;
        logic [21:0] waveform_gap;
        logic [11:0] current_waveform_num;
        logic [11:0] num_waveforms;
        logic [22:0] burst_start_adr;
        logic [2:0]  adr_lsb;
        logic        reserved;         // room for a 3-bit fill type
        logic [1:0]  fill_type;
        logic [22:0] num_fill_bursts;
    } wave_hdr_t;

    // one 128-bit payload, four ways to read it
    typedef union packed {
        fill_hdr_t         fill;
        wave_hdr_t         wave;
        logic [7:0][15:0]  samples;    // samples[0] oldest
        logic [127:0]      raw;        // checksum view
    } rec_payload_u;

    typedef struct packed {
        rec_tag_e     tag;
        rec_payload_u payload;
    } rec_word_t;

    // ddr3 write command
    typedef struct packed {
        logic [25:0] adr;
        rec_word_t   rec;
    } ddr_wr_t;

endpackage

// ==== hdl/fill_sequencer.sv ====
`timescale 1ns/10ps

module fill_sequencer
    import acq_cfg_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  fill_cfg_t   cfg,
    input  logic        adc_valid,
    input  logic        credit_return,
    output logic        adc_ready,
    output logic        sel_fill_hdr,
    output logic        sel_wave_hdr,
    output logic        sel_dat,
    output logic        sel_checksum,
    output logic [11:0] wave_num,
    output logic        busy
);

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [2:0] {
        S_IDLE, S_FILL_HDR, S_WAVE_HDR, S_DATA, S_GAP, S_CHECKSUM, S_DRAIN
    } state_e;

    state_e        state;
    logic [CW-1:0] credits_q;   // free fifo slots as seen from here
    logic [22:0]   dat_cnt;
    logic [21:0]   gap_cnt;
    logic          has_credit;
    logic          spend;
    logic          last_dat;
    logic          last_wave;
    logic          last_gap;

    ////////////////////////////////////////////////////////////
    // selects, gated by credit
    assign has_credit   = credits_q != '0;
    assign sel_fill_hdr = (state == S_FILL_HDR) && has_credit;
    assign sel_wave_hdr = (state == S_WAVE_HDR) && has_credit;
    assign adc_ready    = (state == S_DATA) && has_credit;
    assign sel_dat      = adc_ready && adc_valid;   // word taken on the select cycle
    assign sel_checksum = (state == S_CHECKSUM) && has_credit;
    assign spend        = sel_fill_hdr | sel_wave_hdr | sel_dat | sel_checksum;

    // a count of zero behaves like one
    assign last_dat  = ({1'b0, dat_cnt} + 24'd1) >= {1'b0, cfg.num_fill_bursts};
    assign last_wave = ({1'b0, wave_num} + 13'd1) >= {1'b0, cfg.num_waveforms};
    assign last_gap  = ({1'b0, gap_cnt} + 23'd1) >= {1'b0, cfg.waveform_gap};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits_q <= CW'(FIFO_DEPTH);
        end else begin
            credits_q <= credits_q + CW'(credit_return) - CW'(spend);
        end
    end

    ////////////////////////////////////////////////////////////
    // fill FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            busy     <= 1'b0;
            wave_num <= '0;
            dat_cnt  <= '0;
            gap_cnt  <= '0;
        end else begin
            case (state)
                S_IDLE: if (start) begin
                    state    <= S_FILL_HDR;
                    busy     <= 1'b1;
                    wave_num <= '0;
                end
                S_FILL_HDR: if (has_credit) state <= S_WAVE_HDR;
                S_WAVE_HDR: if (has_credit) begin
                    state   <= S_DATA;
                    dat_cnt <= '0;
                end
                S_DATA: if (sel_dat) begin
                    dat_cnt <= dat_cnt + 23'd1;
                    if (last_dat && last_wave) begin
                        state <= S_CHECKSUM;
                    end else if (last_dat) begin
                        wave_num <= wave_num + 12'd1;   // header sees the new number
                        gap_cnt  <= '0;
                        state    <= (cfg.waveform_gap == '0) ? S_WAVE_HDR : S_GAP;
                    end
                end
                S_GAP: begin
                    gap_cnt <= gap_cnt + 22'd1;
                    if (last_gap) state <= S_WAVE_HDR;
                end
                S_CHECKSUM: if (has_credit) state <= S_DRAIN;
                S_DRAIN: if (credits_q == CW'(FIFO_DEPTH)) begin   // every record popped
                    state <= S_IDLE;
                    busy  <= 1'b0;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sel_fill_hdr, sel_wave_hdr, sel_dat, sel_checksum}));

    // fifo returns no more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits_q <= CW'(FIFO_DEPTH));

endmodule

// ==== hdl/rec_mux.sv ====
`timescale 1ns/10ps

module rec_mux
    import acq_cfg_pkg::*;
    import acq_rec_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  fill_cfg_t   cfg,
    input  adc_word_t   adc_word,
    input  logic [3:0]  xadc_alarms,
    input  logic [11:0] wave_num,
    input  logic        sel_fill_hdr,
    input  logic        sel_wave_hdr,
    input  logic        sel_dat,
    input  logic        sel_checksum,
    output rec_word_t   rec,
    output logic        rec_push
);

    fill_hdr_t    fill_hdr;
    wave_hdr_t    wave_hdr;
    rec_payload_u dat_pl;
    logic [127:0] checksum;   // running xor, tag excluded
    logic         any_sel;

    assign any_sel = sel_fill_hdr | sel_wave_hdr | sel_dat | sel_checksum;

    ////////////////////////////////////////////////////////////
    // fill header
    always_comb begin
        fill_hdr                 = '0;   // async, cbuf, self-trig stay 0
        fill_hdr.marker          = 2'b01;
        fill_hdr.channel_tag     = cfg.channel_tag;
        fill_hdr.waveform_gap    = cfg.waveform_gap;
        fill_hdr.num_waveforms   = cfg.num_waveforms;
        fill_hdr.burst_start_adr = cfg.burst_start_adr;
        fill_hdr.num_fill_bursts = cfg.num_fill_bursts;
        fill_hdr.fill_type       = cfg.fill_type;
        fill_hdr.fill_num        = cfg.fill_num;
    end

    ////////////////////////////////////////////////////////////
    // waveform header
    always_comb begin
        wave_hdr                      = '0;
        wave_hdr.marker               = 2'b01;
        wave_hdr.alarms               = xadc_alarms;   // captured with the record
        wave_hdr.channel_tag          = cfg.channel_tag;
        wave_hdr.waveform_gap         = cfg.waveform_gap;
        wave_hdr.current_waveform_num = wave_num;
        wave_hdr.num_waveforms        = cfg.num_waveforms;
        wave_hdr.burst_start_adr      = cfg.burst_start_adr;
        wave_hdr.fill_type            = cfg.fill_type;
        wave_hdr.num_fill_bursts      = cfg.num_fill_bursts;
    end

    ////////////////////////////////////////////////////////////
    // data, over-range dropped, sign into the top nibble
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            dat_pl.samples[2*i]   = {{4{adc_word[i].samp_a[11]}}, adc_word[i].samp_a};
            dat_pl.samples[2*i+1] = {{4{adc_word[i].samp_b[11]}}, adc_word[i].samp_b};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rec_push <= 1'b0;
        end else begin
            rec_push <= any_sel;   // one cycle behind the select
        end
    end

    // output record and checksum, one select at a time
    always_ff @(posedge clk) begin
        if (sel_fill_hdr) begin
            rec.tag          <= REC_FILL_HDR;
            rec.payload.fill <= fill_hdr;
            checksum         <= fill_hdr;              // new fill, fresh sum
        end else if (sel_wave_hdr) begin
            rec.tag          <= REC_WAVE_HDR;
            rec.payload.wave <= wave_hdr;
            checksum         <= checksum ^ wave_hdr;
        end else if (sel_dat) begin
            rec.tag          <= REC_DATA;
            rec.payload      <= dat_pl;
            checksum         <= checksum ^ dat_pl.raw;
        end else if (sel_checksum) begin
            rec.tag          <= REC_CHECKSUM;
            rec.payload.raw  <= checksum;
        end
    end

    a_push_follows_sel: assert property (@(posedge clk) disable iff (!rst_n)
        rec_push == $past(any_sel));

endmodule

// ==== hdl/rec_fifo.sv ====
`timescale 1ns/10ps

module rec_fifo
    import acq_rec_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic      clk,
    input  logic      rst_n,
    input  rec_word_t rec,
    input  logic      rec_push,
    input  logic      pop,
    output rec_word_t head,
    output logic      not_empty,
    output logic      credit_return
);

    localparam int AW = $clog2(FIFO_DEPTH);

    rec_word_t     mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;   // wraps on its own, depth is a power of two
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;

    assign head          = mem[rd_ptr];
    assign not_empty     = count != '0;
    assign full          = count == (AW + 1)'(FIFO_DEPTH);
    assign credit_return = pop;   // slot freed, hand it back

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (rec_push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)      rd_ptr <= rd_ptr + 1'b1;
            case ({rec_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (rec_push) mem[wr_ptr] <= rec;
    end

    // credits upstream keep this from firing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        rec_push |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty);

endmodule

// ==== hdl/ddr_burst_writer.sv ====
`timescale 1ns/10ps

module ddr_burst_writer
    import acq_rec_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  rec_word_t head,
    input  logic      not_empty,
    input  logic      ddr_ready,
    output logic      pop,
    output ddr_wr_t   ddr_wr,
    output logic      ddr_valid
);

    logic [25:0] adr_cnt;   // next ddr address
    logic [25:0] wr_adr;
    logic        in_fill;   // between fill header and checksum

    // take a record when the command slot is free or draining
    assign pop = not_empty && (!ddr_valid || ddr_ready);

    // fill header restarts the address run
    assign wr_adr = (head.tag == REC_FILL_HDR) ?
                    {head.payload.fill.burst_start_adr, 3'b000} : adr_cnt;

    ////////////////////////////////////////////////////////////
    // command handshake and address counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ddr_valid <= 1'b0;
            adr_cnt   <= '0;
            in_fill   <= 1'b0;
        end else if (pop) begin
            ddr_valid <= 1'b1;
            adr_cnt   <= wr_adr + 26'd1;
            in_fill   <= head.tag != REC_CHECKSUM;   // checksum ends the fill
        end else if (ddr_ready) begin
            ddr_valid <= 1'b0;   // transferred, nothing new
        end
    end

    // held while ddr_ready is low
    always_ff @(posedge clk) begin
        if (pop) begin
            ddr_wr.adr <= wr_adr;
            ddr_wr.rec <= head;
        end
    end

    // record order from the sequencer
    a_hdr_opens_fill: assert property (@(posedge clk) disable iff (!rst_n)
        pop && head.tag == REC_FILL_HDR |-> !in_fill);

    a_rec_inside_fill: assert property (@(posedge clk) disable iff (!rst_n)
        pop && head.tag != REC_FILL_HDR |-> in_fill);

endmodule

// ==== hdl/adc_acq_top.sv ====
`timescale 1ns/10ps

module adc_acq_top
    import acq_cfg_pkg::*;
    import acq_rec_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  fill_cfg_t  cfg,
    input  logic [3:0] xadc_alarms,
    input  adc_word_t  adc_word,
    input  logic       adc_valid,
    output logic       adc_ready,
    output ddr_wr_t    ddr_wr,
    output logic       ddr_valid,
    input  logic       ddr_ready,
    output logic       busy
);

    logic        sel_fill_hdr;
    logic        sel_wave_hdr;
    logic        sel_dat;
    logic        sel_checksum;
    logic [11:0] wave_num;
    rec_word_t   rec;
    logic        rec_push;
    rec_word_t   head;
    logic        not_empty;
    logic        pop;
    logic        credit_return;

    ////////////////////////////////////////////////////////////
    // producer, formatter, buffer, consumer
    fill_sequencer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fill_sequencer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .cfg           (cfg),
        .adc_valid     (adc_valid),
        .credit_return (credit_return),
        .adc_ready     (adc_ready),
        .sel_fill_hdr  (sel_fill_hdr),
        .sel_wave_hdr  (sel_wave_hdr),
        .sel_dat       (sel_dat),
        .sel_checksum  (sel_checksum),
        .wave_num      (wave_num),
        .busy          (busy)
    );

    rec_mux rec_mux_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .adc_word     (adc_word),
        .xadc_alarms  (xadc_alarms),
        .wave_num     (wave_num),
        .sel_fill_hdr (sel_fill_hdr),
        .sel_wave_hdr (sel_wave_hdr),
        .sel_dat      (sel_dat),
        .sel_checksum (sel_checksum),
        .rec          (rec),
        .rec_push     (rec_push)
    );

    rec_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)   // same depth as the credit pool
    ) rec_fifo_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .rec           (rec),
        .rec_push      (rec_push),
        .pop           (pop),
        .head          (head),
        .not_empty     (not_empty),
        .credit_return (credit_return)
    );

    ddr_burst_writer ddr_burst_writer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .not_empty (not_empty),
        .ddr_ready (ddr_ready),
        .pop       (pop),
        .ddr_wr    (ddr_wr),
        .ddr_valid (ddr_valid)
    );

endmodule

// ==== bench/tb_adc_acq.sv ====
`timescale 1ns/10ps

module tb_adc_acq
    import acq_cfg_pkg::*;
    import acq_rec_pkg::*;
();

    localparam int FIFO_DEPTH = 8;
    localparam int MAX_CYCLES = 20000;   // per wait loop

    logic       clk;
    logic       rst_n;
    logic       start;
    fill_cfg_t  cfg;
    logic [3:0] xadc_alarms;
    adc_word_t  adc_word;
    logic       adc_valid;
    logic       adc_ready;
    ddr_wr_t    ddr_wr;
    logic       ddr_valid;
    logic       ddr_ready;
    logic       busy;

    rec_word_t exp_q[$];    // records expected for the current fill
    adc_word_t word_q[$];   // adc words sent during the current fill
    int        rec_total;   // records seen over the whole run
    int        exp_total;

    adc_acq_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) adc_acq_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg         (cfg),
        .xadc_alarms (xadc_alarms),
        .adc_word    (adc_word),
        .adc_valid   (adc_valid),
        .adc_ready   (adc_ready),
        .ddr_wr      (ddr_wr),
        .ddr_valid   (ddr_valid),
        .ddr_ready   (ddr_ready),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 100 MHz
    end

    // every ddr transfer of the run, between fills too
    always @(posedge clk) begin
        if (rst_n && ddr_valid && ddr_ready) rec_total++;
    end

    ////////////////////////////////////////////////////////////
    // error exit and compare tasks
    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rec(input string name, input rec_word_t got, input rec_word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_adr(input string name, input logic [25:0] got,
                             input logic [25:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                    $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    function automatic rec_word_t fill_hdr_rec(input fill_cfg_t c);
        rec_word_t r;
        r = '0;   // async and self-trig bits zero
        r.tag                          = REC_FILL_HDR;
        r.payload.fill.marker          = 2'b01;
        r.payload.fill.channel_tag     = c.channel_tag;
        r.payload.fill.waveform_gap    = c.waveform_gap;
        r.payload.fill.num_waveforms   = c.num_waveforms;
        r.payload.fill.burst_start_adr = c.burst_start_adr;
        r.payload.fill.num_fill_bursts = c.num_fill_bursts;
        r.payload.fill.fill_type       = c.fill_type;
        r.payload.fill.fill_num        = c.fill_num;
        return r;
    endfunction

    function automatic rec_word_t wave_hdr_rec(input fill_cfg_t c, input logic [3:0] alarms,
                                               input logic [11:0] wnum);
        rec_word_t r;
        r = '0;
        r.tag                               = REC_WAVE_HDR;
        r.payload.wave.marker               = 2'b01;
        r.payload.wave.alarms               = alarms;
        r.payload.wave.channel_tag          = c.channel_tag;
        r.payload.wave.waveform_gap         = c.waveform_gap;
        r.payload.wave.current_waveform_num = wnum;   // counts from 0
        r.payload.wave.num_waveforms        = c.num_waveforms;
        r.payload.wave.burst_start_adr      = c.burst_start_adr;
        r.payload.wave.fill_type            = c.fill_type;
        r.payload.wave.num_fill_bursts      = c.num_fill_bursts;
        return r;
    endfunction

    function automatic rec_word_t data_rec(input adc_word_t w);
        rec_word_t r;
        r = '0;
        r.tag = REC_DATA;
        for (int i = 0; i < 4; i++) begin
            r.payload.samples[2*i]   = 16'($signed(w[i].samp_a));   // ovr bit left out
            r.payload.samples[2*i+1] = 16'($signed(w[i].samp_b));
        end
        return r;
    endfunction

    // whole fill in order, checksum last
    function automatic void build_expected(input fill_cfg_t c, input logic [3:0] alarms);
        rec_word_t    r;
        logic [127:0] sum;
        int           k;
        exp_q.delete();
        k = 0;
        r = fill_hdr_rec(c);
        sum = r.payload.raw;   // fill header seeds the sum
        exp_q.push_back(r);
        for (int w = 0; w < int'(c.num_waveforms); w++) begin
            r = wave_hdr_rec(c, alarms, 12'(w));
            sum = sum ^ r.payload.raw;
            exp_q.push_back(r);
            for (int d = 0; d < int'(c.num_fill_bursts); d++) begin
                r = data_rec(word_q[k]);
                sum = sum ^ r.payload.raw;
                exp_q.push_back(r);
                k++;
            end
        end
        r = '0;
        r.tag = REC_CHECKSUM;
        r.payload.raw = sum;
        exp_q.push_back(r);
    endfunction

    function automatic fill_cfg_t make_cfg(input logic [23:0] num, input logic [22:0] bursts,
                                           input logic [11:0] waves, input logic [21:0] gap,
                                           input logic [22:0] adr);
        fill_cfg_t c;
        c.fill_num        = num;
        c.fill_type       = 2'd1;
        c.num_fill_bursts = bursts;
        c.burst_start_adr = adr;
        c.num_waveforms   = waves;
        c.waveform_gap    = gap;
        c.channel_tag     = 12'h3a5;
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    task automatic make_random_words(input int n);
        adc_word_t w;
        word_q.delete();
        for (int i = 0; i < n; i++) begin
            for (int p = 0; p < 4; p++) begin
                w[p].samp_a = 12'($urandom);
                w[p].ovr_a  = 1'($urandom);
                w[p].samp_b = 12'($urandom);
                w[p].ovr_b  = 1'($urandom);
            end
            word_q.push_back(w);
        end
    endtask

    // alternating negative and positive full scale, over-range always set
    task automatic make_full_scale_words(input int n);
        adc_word_t w;
        word_q.delete();
        for (int i = 0; i < n; i++) begin
            for (int p = 0; p < 4; p++) begin
                w[p].samp_a = ((p + i) % 2 == 0) ? 12'h800 : 12'h7ff;
                w[p].samp_b = ((p + i) % 2 == 0) ? 12'h7ff : 12'h800;
                w[p].ovr_a  = 1'b1;
                w[p].ovr_b  = 1'b1;
            end
            word_q.push_back(w);
        end
    endtask

    // one fill from start pulse to busy low, every write checked on transfer
    task automatic run_fill(input fill_cfg_t c, input logic [3:0] alarms,
                            input bit random_ready);
        int          idx;
        int          got;
        int          cyc;
        logic [25:0] exp_adr;
        build_expected(c, alarms);
        exp_total = exp_total + 2 + int'(c.num_waveforms) * (1 + int'(c.num_fill_bursts));
        idx = 0;
        got = 0;
        exp_adr = {c.burst_start_adr, 3'b000};
        @(posedge clk);
        cfg         <= c;
        xadc_alarms <= alarms;
        start       <= 1'b1;
        adc_valid   <= 1'b1;
        adc_word    <= word_q[0];
        ddr_ready   <= 1'b1;
        for (cyc = 0; got < exp_q.size(); cyc++) begin
            if (cyc == MAX_CYCLES) stop_on_error("timeout: fill did not write all records");
            @(posedge clk);
            if (cyc == 1) check_flag("busy", busy, 1'b1);   // one cycle after start
            if (adc_valid && adc_ready) idx++;
            if (ddr_valid && ddr_ready) begin
                check_rec("ddr_wr.rec", ddr_wr.rec, exp_q[got]);
                check_adr("ddr_wr.adr", ddr_wr.adr, exp_adr);
                exp_adr++;
                got++;
            end
            start     <= 1'b0;
            adc_valid <= (idx < word_q.size()) && (!random_ready || ($urandom % 4) != 0);
            if (idx < word_q.size()) adc_word <= word_q[idx];
            ddr_ready <= random_ready ? (($urandom % 3) != 0) : 1'b1;
        end
        for (cyc = 0; busy; cyc++) begin
            if (cyc == MAX_CYCLES) stop_on_error("timeout: busy stayed high after the checksum");
            @(posedge clk);
            if (ddr_valid && ddr_ready) stop_on_error("a record was written after the checksum");
        end
        check_flag("busy", busy, 1'b0);
        if (idx != word_q.size()) begin
            stop_on_error($sformatf("the DUT took %0d ADC words but the fill needs %0d",
                                    idx, word_q.size()));
        end
        adc_valid <= 1'b0;
        ddr_ready <= 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    task automatic test_single_wave();
        make_random_words(4);
        run_fill(make_cfg(24'h000101, 23'd4, 12'd1, 22'd0, 23'h001234), 4'ha, 1'b0);
    endtask

    task automatic test_three_waves();
        make_random_words(9);   // 3 waveforms of 3 records
        run_fill(make_cfg(24'h000202, 23'd3, 12'd3, 22'd6, 23'h020000), 4'h5, 1'b0);
    endtask

    task automatic test_backpressure();
        make_random_words(48);
        run_fill(make_cfg(24'h000303, 23'd24, 12'd2, 22'd1, 23'h7ffff0), 4'h3, 1'b1);
    endtask

    task automatic test_full_scale();
        make_full_scale_words(2);
        run_fill(make_cfg(24'h000404, 23'd2, 12'd1, 22'd0, 23'h000010), 4'h0, 1'b0);
    endtask

    // back to back fills, the second must start clean
    task automatic test_busy_refill();
        make_random_words(5);
        run_fill(make_cfg(24'h000505, 23'd5, 12'd1, 22'd0, 23'h000100), 4'hf, 1'b0);
        make_random_words(4);
        run_fill(make_cfg(24'h000506, 23'd2, 12'd2, 22'd3, 23'h000200), 4'h9, 1'b1);
    endtask

    initial begin
        void'($urandom(52206));
        rst_n       <= 1'b0;
        start       <= 1'b0;
        cfg         <= '0;
        xadc_alarms <= '0;
        adc_word    <= '0;
        adc_valid   <= 1'b0;
        ddr_ready   <= 1'b0;
        rec_total = 0;
        exp_total = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag("busy", busy, 1'b0);   // idle after reset
        check_flag("adc_ready", adc_ready, 1'b0);
        check_flag("ddr_valid", ddr_valid, 1'b0);
        test_single_wave();
        test_three_waves();
        test_backpressure();
        test_full_scale();
        test_busy_refill();
        if (rec_total == exp_total && rec_total > 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d records written over the run, %0d expected",
                                    rec_total, exp_total));
        end
    end

endmodule

// ==== files.f ====
hdl/acq_cfg_pkg.sv
hdl/acq_rec_pkg.sv
hdl/fill_sequencer.sv
hdl/rec_mux.sv
hdl/rec_fifo.sv
hdl/ddr_burst_writer.sv
hdl/adc_acq_top.sv
bench/tb_adc_acq.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, fail on the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_acq -f files.f \
    > build.log 2>&1 || { cat build.log; echo "compile failed"; exit 1; }
./obj_dir/Vtb_adc_acq > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
